//--- eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W = 11;              // 2 KB device
    localparam int BLK_W  = 3;               // block number bits in the control byte

    localparam logic [3:0] DEV_CODE = 4'b1010;

    // last step index of an engine command, one step per clk
    localparam logic [4:0] COND_LAST_STEP = 5'd3;    // start, restart, stop
    localparam logic [4:0] BYTE_LAST_STEP = 5'd17;   // 8 bits + ack

    typedef enum logic [2:0] {
        CMD_START,
        CMD_RESTART,
        CMD_WRITE,
        CMD_READ_ACK,
        CMD_READ_NACK,
        CMD_STOP
    } bus_cmd_t;

    // main request machine
    typedef enum logic [3:0] {
        IDLE,
        WRITE_START,
        CTRL_WRITE,
        ADDR_WRITE,
        DATA_WRITE,
        READ_START,
        CTRL_READ,
        DATA_READ,
        STOP,
        ACKN
    } seq_state_t;

    // control byte, built by fields and shifted as a whole
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0]       dev;
            logic [BLK_W-1:0] block;    // upper address bits
            logic             rnw;      // 1 = read
        } f;
    } ctrl_byte_u;

endpackage

`default_nettype wire

//--- eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_sequencer (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          wr,
    input  wire                          rd,
    input  wire [eeprom_pkg::ADDR_W-1:0] addr,
    input  wire [7:0]                    wdata,
    output logic [7:0]                   rdata,
    output logic                         ack,
    output logic                         nack,
    i2c_bus_if.seq                       bus
);

    eeprom_pkg::seq_state_t  state;
    eeprom_pkg::seq_state_t  next_state;
    eeprom_pkg::ctrl_byte_u  ctrl;

    logic                          pending;     // command issued, waiting for done
    logic                          is_read;
    logic                          nack_flag;   // sticky
    logic                          write_phase;
    logic [eeprom_pkg::ADDR_W-1:0] addr_q;
    logic [7:0]                    wdata_q;

    assign bus.cmd_valid = !pending &&
                           (state != eeprom_pkg::IDLE) && (state != eeprom_pkg::ACKN);

    assign write_phase = (state == eeprom_pkg::CTRL_WRITE) ||
                         (state == eeprom_pkg::ADDR_WRITE) ||
                         (state == eeprom_pkg::DATA_WRITE) ||
                         (state == eeprom_pkg::CTRL_READ);

    assign ack  = (state == eeprom_pkg::ACKN);
    assign nack = ack && nack_flag;

    always_comb begin
        ctrl.f.dev   = eeprom_pkg::DEV_CODE;
        ctrl.f.block = addr_q[eeprom_pkg::ADDR_W-1 -: eeprom_pkg::BLK_W];
        ctrl.f.rnw   = (state == eeprom_pkg::CTRL_READ);

        bus.cmd     = eeprom_pkg::CMD_WRITE;
        bus.tx_byte = ctrl.raw;
        next_state  = state;
        case (state)
            eeprom_pkg::WRITE_START: begin
                bus.cmd    = eeprom_pkg::CMD_START;
                next_state = eeprom_pkg::CTRL_WRITE;
            end
            eeprom_pkg::CTRL_WRITE: next_state = eeprom_pkg::ADDR_WRITE;
            eeprom_pkg::ADDR_WRITE: begin
                bus.tx_byte = addr_q[eeprom_pkg::ADDR_W-eeprom_pkg::BLK_W-1:0];
                next_state  = is_read ? eeprom_pkg::READ_START : eeprom_pkg::DATA_WRITE;
            end
            eeprom_pkg::DATA_WRITE: begin
                bus.tx_byte = wdata_q;
                next_state  = eeprom_pkg::STOP;
            end
            eeprom_pkg::READ_START: begin
                bus.cmd    = eeprom_pkg::CMD_RESTART;
                next_state = eeprom_pkg::CTRL_READ;
            end
            eeprom_pkg::CTRL_READ: next_state = eeprom_pkg::DATA_READ;
            eeprom_pkg::DATA_READ: begin
                bus.cmd    = eeprom_pkg::CMD_READ_NACK;  // single byte only
                next_state = eeprom_pkg::STOP;
            end
            eeprom_pkg::STOP: begin
                bus.cmd    = eeprom_pkg::CMD_STOP;
                next_state = eeprom_pkg::ACKN;
            end
            default: next_state = state;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= eeprom_pkg::IDLE;
            pending   <= 1'b0;
            is_read   <= 1'b0;
            nack_flag <= 1'b0;
        end else begin
            if (bus.cmd_valid) begin
                pending <= 1'b1;
            end
            case (state)
                eeprom_pkg::IDLE: begin
                    if (wr || rd) begin
                        is_read   <= ~wr;     // write wins
                        nack_flag <= 1'b0;
                        state     <= eeprom_pkg::WRITE_START;
                    end
                end
                eeprom_pkg::ACKN: state <= eeprom_pkg::IDLE;
                default: begin
                    if (bus.done) begin
                        pending <= 1'b0;
                        if (write_phase) begin
                            nack_flag <= nack_flag | bus.ack_in;
                        end
                        state <= next_state;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == eeprom_pkg::IDLE && (wr || rd)) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == eeprom_pkg::DATA_READ && bus.done) begin
            rdata <= bus.rx_byte;
        end
    end

endmodule

`default_nettype wire

//--- eeprom_wr.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_wr (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          wr,
    input  wire                          rd,
    input  wire [eeprom_pkg::ADDR_W-1:0] addr,
    input  wire [7:0]                    wdata,
    output logic [7:0]                   rdata,
    output logic                         ack,
    output logic                         nack,
    output logic                         scl,
    inout  wire                          sda
);

    wire sda_oe;
    wire sda_in;

    i2c_bus_if bus_i ();

    eeprom_sequencer seq_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack),
        .nack  (nack),
        .bus   (bus_i.seq)
    );

    i2c_bus_engine engine_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus_i.engine),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

    // open drain, the pull-up sits outside
    assign sda    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

`default_nettype wire

//--- flist.f
eeprom_pkg.sv
i2c_bus_if.sv
i2c_bus_engine.sv
eeprom_sequencer.sv
eeprom_wr.sv
tb_eeprom_model.sv
tb_eeprom_wr.sv

//--- i2c_bus_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bus_engine (
    input  wire        clk,
    input  wire        rst_n,
    i2c_bus_if.engine  bus,
    output logic       scl,
    output logic       sda_oe,     // high pulls sda low
    input  wire        sda_in
);

    logic                  busy;
    logic [4:0]            step;       // current step, one per clk
    eeprom_pkg::bus_cmd_t  cur_cmd;
    logic                  scl_d;      // scl level wanted, moved to scl on falling clk
    logic [7:0]            sh_q;       // shared shift register, out and in
    logic                  is_byte;
    logic [4:0]            last_step;

    logic [4:0]            nxt_step;
    eeprom_pkg::bus_cmd_t  nxt_cmd;
    logic [7:0]            nxt_sh;
    logic                  nxt_scl;
    logic                  nxt_oe;

    assign is_byte = (cur_cmd == eeprom_pkg::CMD_WRITE) ||
                     (cur_cmd == eeprom_pkg::CMD_READ_ACK) ||
                     (cur_cmd == eeprom_pkg::CMD_READ_NACK);

    assign last_step = is_byte ? eeprom_pkg::BYTE_LAST_STEP : eeprom_pkg::COND_LAST_STEP;

    assign bus.rx_byte = sh_q;

    // line levels for the step about to begin
    always_comb begin
        nxt_step = busy ? step + 5'd1 : 5'd0;
        nxt_cmd  = busy ? cur_cmd : bus.cmd;
        if (busy) begin
            nxt_sh = sh_q;
        end else if (bus.cmd == eeprom_pkg::CMD_WRITE) begin
            nxt_sh = bus.tx_byte;
        end else begin
            nxt_sh = 8'hff;     // reads keep sda released on data bits
        end
        nxt_scl = scl_d;
        nxt_oe  = sda_oe;
        case (nxt_cmd)
            eeprom_pkg::CMD_START,
            eeprom_pkg::CMD_RESTART: begin
                // scl up with sda free, then sda falls, then scl falls
                nxt_scl = ~nxt_step[1];
                nxt_oe  = nxt_step[1];
            end
            eeprom_pkg::CMD_STOP: begin
                nxt_scl = (nxt_step != 5'd0);
                nxt_oe  = (nxt_step != 5'd3);   // sda rises with scl high
            end
            default: begin
                nxt_scl = ~nxt_step[0];
                if (!nxt_step[0]) begin     // sda only moves at the start of a bit
                    if (nxt_step[4]) begin
                        nxt_oe = (nxt_cmd == eeprom_pkg::CMD_READ_ACK);
                    end else begin
                        nxt_oe = ~nxt_sh[7];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step     <= 5'd0;
            cur_cmd  <= eeprom_pkg::CMD_START;
            scl_d    <= 1'b1;
            sda_oe   <= 1'b0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (!busy) begin
                if (bus.cmd_valid) begin
                    busy    <= 1'b1;
                    step    <= nxt_step;
                    cur_cmd <= bus.cmd;
                    scl_d   <= nxt_scl;
                    sda_oe  <= nxt_oe;
                end
            end else if (step == last_step) begin
                busy     <= 1'b0;   // lines hold until the next command
                bus.done <= 1'b1;
            end else begin
                step   <= nxt_step;
                scl_d  <= nxt_scl;
                sda_oe <= nxt_oe;
            end
        end
    end

    // even byte steps end with scl high, sample there
    always_ff @(posedge clk) begin
        if (!busy && bus.cmd_valid) begin
            sh_q <= nxt_sh;
        end else if (busy && is_byte && !step[0]) begin
            if (step[4]) begin
                bus.ack_in <= sda_in;
            end else begin
                sh_q <= {sh_q[6:0], sda_in};
            end
        end
    end

    // half a clk after the data flops
    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl <= 1'b1;
        end else begin
            scl <= scl_d;
        end
    end

endmodule

`default_nettype wire

//--- i2c_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface i2c_bus_if;

    // command side, from the sequencer
    logic                  cmd_valid;   // single-cycle, only while engine idle
    eeprom_pkg::bus_cmd_t  cmd;
    logic [7:0]            tx_byte;

    // result side, from the engine
    logic                  done;        // one pulse per command
    logic [7:0]            rx_byte;
    logic                  ack_in;      // low = slave acknowledged

    modport seq (
        output cmd_valid,
        output cmd,
        output tx_byte,
        input  done,
        input  rx_byte,
        input  ack_in
    );

    modport engine (
        input  cmd_valid,
        input  cmd,
        input  tx_byte,
        output done,
        output rx_byte,
        output ack_in
    );

endinterface

`default_nettype wire

//--- tb_eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_model (
    input  wire scl,
    inout  wire sda,
    input  wire present,     // low = device never answers
    output int  start_cnt,
    output int  stop_cnt,
    output int  proto_err
);

    logic [7:0]             mem [0:2047];
    logic [10:0]            ptr;
    logic [7:0]             shreg;
    logic [7:0]             tx;
    eeprom_pkg::ctrl_byte_u cb;
    int                     bit_cnt;    // scl rises in the current 9-bit frame
    int                     byte_idx;
    logic                   in_frame;
    logic                   addressed;
    logic                   reading;    // slave owns the data bits
    logic                   send_next;
    logic                   drive_low;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        int j;
        for (j = 0; j < 2048; j++) begin
            mem[j] = j[7:0] ^ {j[10:8], 5'b01101};
        end
        start_cnt = 0;
        stop_cnt  = 0;
        proto_err = 0;
        ptr       = '0;
        shreg     = '0;
        tx        = '0;
        bit_cnt   = 0;
        byte_idx  = 0;
        in_frame  = 1'b0;
        addressed = 1'b0;
        reading   = 1'b0;
        send_next = 1'b0;
        drive_low = 1'b0;
    end

    // a complete byte from the master
    task automatic take_byte();
        if (byte_idx == 0) begin
            cb.raw    = shreg;
            addressed = present && (cb.f.dev == eeprom_pkg::DEV_CODE);
            if (addressed) begin
                ptr[10:8] = cb.f.block;
                send_next = cb.f.rnw;
            end
        end else if (addressed && byte_idx == 1) begin
            ptr[7:0] = shreg;    // word address
        end else if (addressed) begin
            mem[ptr] = shreg;
            ptr[7:0] = ptr[7:0] + 8'd1;
        end
        byte_idx++;
    endtask

    // start, only legal at a frame boundary
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            if (bit_cnt > 1) begin
                proto_err++;
            end else begin
                start_cnt++;
                in_frame  = 1'b1;
                bit_cnt   = 0;
                byte_idx  = 0;
                addressed = 1'b0;
                reading   = 1'b0;
                send_next = 1'b0;
            end
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && in_frame === 1'b1) begin
            if (bit_cnt > 1) begin
                proto_err++;
            end else begin
                stop_cnt++;
                in_frame  = 1'b0;
                bit_cnt   = 0;
                reading   = 1'b0;
                drive_low = 1'b0;
            end
        end
    end

    always @(posedge scl) begin
        if (in_frame === 1'b1) begin
            bit_cnt++;
            if (bit_cnt <= 8) begin
                shreg = {shreg[6:0], sda};
            end else if (reading) begin
                send_next = (sda == 1'b0);   // master ack asks for another byte
            end
        end
    end

    // sda only changes here, with scl low
    always @(negedge scl) begin
        if (in_frame === 1'b1) begin
            if (bit_cnt == 8) begin
                if (reading) begin
                    drive_low = 1'b0;
                end else begin
                    take_byte();
                    drive_low = addressed;
                end
            end else if (bit_cnt == 9) begin
                bit_cnt   = 0;
                drive_low = 1'b0;
                reading   = send_next;
                send_next = 1'b0;
                if (reading) begin
                    tx        = mem[ptr];
                    ptr[7:0]  = ptr[7:0] + 8'd1;
                    drive_low = ~tx[7];
                end
            end else if (reading && bit_cnt >= 1) begin
                drive_low = ~tx[7 - bit_cnt];
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_eeprom_wr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_wr;

    localparam int MAX_STEPS = 64;
    localparam int N_RANDOM  = 40;

    logic                          clk;
    logic                          rst_n;
    logic                          wr;
    logic                          rd;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic [7:0]                    wdata;
    logic [7:0]                    rdata;
    logic                          ack;
    logic                          nack;
    logic                          scl;
    wire                           sda;
    logic                          present;
    int                            start_cnt;
    int                            stop_cnt;
    int                            proto_err;

    // stimulus table with expected results
    logic                          t_rd      [MAX_STEPS];
    logic [eeprom_pkg::ADDR_W-1:0] t_addr    [MAX_STEPS];
    logic [7:0]                    t_data    [MAX_STEPS];
    logic                          t_present [MAX_STEPS];
    logic [7:0]                    t_rdata   [MAX_STEPS];
    logic                          t_nack    [MAX_STEPS];
    int                            n_steps;
    logic                          table_ready;

    logic [7:0]                    ref_mem   [0:2047];
    logic [10:0]                   used_addr [N_RANDOM];
    int                            n_used;
    int                            errors;

    pullup (sda);

    eeprom_wr eeprom_wr_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack),
        .nack  (nack),
        .scl   (scl),
        .sda   (sda)
    );

    tb_eeprom_model model_i (
        .scl       (scl),
        .sda       (sda),
        .present   (present),
        .start_cnt (start_cnt),
        .stop_cnt  (stop_cnt),
        .proto_err (proto_err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [7:0] fill_value(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], 5'b01101};
    endfunction

    task automatic compare_value(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic add_step(input logic is_rd, input logic [10:0] a, input logic [7:0] d,
                            input logic pres);
        t_rd[n_steps]      = is_rd;
        t_addr[n_steps]    = a;
        t_data[n_steps]    = d;
        t_present[n_steps] = pres;
        t_nack[n_steps]    = !pres;
        t_rdata[n_steps]   = 8'h00;
        if (is_rd) begin
            t_rdata[n_steps] = pres ? ref_mem[a] : 8'hff;   // released bus reads ones
        end else if (pres) begin
            ref_mem[a] = d;
        end
        n_steps++;
    endtask

    task automatic build_table();
        int          j;
        logic        is_rd;
        logic [10:0] a;
        n_steps = 0;
        n_used  = 0;
        for (j = 0; j < 2048; j++) begin
            ref_mem[j] = fill_value(j[10:0]);
        end
        add_step(1'b0, 11'h123, 8'ha5, 1'b1);
        add_step(1'b1, 11'h123, 8'h00, 1'b1);
        // same word address in four blocks
        add_step(1'b0, 11'h045, 8'h11, 1'b1);
        add_step(1'b0, 11'h245, 8'h22, 1'b1);
        add_step(1'b0, 11'h745, 8'h77, 1'b1);
        add_step(1'b1, 11'h045, 8'h00, 1'b1);
        add_step(1'b1, 11'h245, 8'h00, 1'b1);
        add_step(1'b1, 11'h745, 8'h00, 1'b1);
        add_step(1'b1, 11'h545, 8'h00, 1'b1);   // untouched block
        add_step(1'b0, 11'h123, 8'h3c, 1'b0);   // device absent
        add_step(1'b1, 11'h123, 8'h00, 1'b0);
        add_step(1'b1, 11'h123, 8'h00, 1'b1);
        for (j = 0; j < N_RANDOM; j++) begin
            is_rd = $urandom % 2;
            if (is_rd && n_used > 0 && ($urandom % 4) != 0) begin
                a = used_addr[$urandom % n_used];
            end else begin
                a = $urandom % 2048;
            end
            add_step(is_rd, a, $urandom, 1'b1);
            if (!is_rd) begin
                used_addr[n_used] = a;
                n_used++;
            end
        end
        table_ready = 1'b1;
    endtask

    task automatic run_step(input int i);
        int starts_before;
        int stops_before;
        int proto_before;
        @(negedge clk);
        starts_before = start_cnt;
        stops_before  = stop_cnt;
        proto_before  = proto_err;
        present = t_present[i];
        addr    = t_addr[i];
        wdata   = t_data[i];
        wr      = !t_rd[i];
        rd      = t_rd[i];
        @(negedge clk);
        while (!ack) @(negedge clk);
        wr = 1'b0;
        rd = 1'b0;
        compare_value("nack", nack, t_nack[i]);
        if (t_rd[i]) begin
            compare_value("rdata", rdata, t_rdata[i]);
        end
        compare_value("start count", start_cnt - starts_before, t_rd[i] ? 2 : 1);
        compare_value("stop count", stop_cnt - stops_before, 1);
        assert (proto_err == proto_before) else
            $display("sda changed while scl was high during request %0d", i);
    endtask

    // ends the run if a request never finishes
    initial begin
        wait (table_ready === 1'b1);
        repeat (n_steps * 100 * 18 + 2) @(posedge clk);
        $display("timeout: %0d requests did not finish in time", n_steps);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int i;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = 8'h00;
        present     = 1'b1;
        rst_n       = 1'b0;
        errors      = 0;
        table_ready = 1'b0;
        void'($urandom(32'h0678_592c));
        build_table();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("ack", ack, 1'b0);
        compare_value("nack", nack, 1'b0);
        compare_value("scl", scl, 1'b1);
        compare_value("sda", sda, 1'b1);
        for (i = 0; i < n_steps; i++) begin
            run_step(i);
        end
        repeat (4) @(negedge clk);
        $display("check errors: %0d, bus protocol errors: %0d", errors, proto_err);
        if (errors == 0 && proto_err == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
